/* build.f */
+incdir+source
source/kdi_scrmbl_pkg.sv
source/kdi_req_pkg.sv
source/kdi_req_decode.sv
source/kdi_ctrl_fsm.sv
source/kdi_key_store.sv
source/kdi_top.sv
verification/kdi_assertions.sv
verification/kdi_tb.sv

/* source/kdi_ctrl_fsm.sv */
// Key derivation control FSM

`timescale 1ns/1ps
`include "kdi_defs.svh"

module kdi_ctrl_fsm
  import kdi_scrmbl_pkg::*;
  import kdi_req_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          kdi_en_i,
  input  logic          escalate_i,
  input  logic          req_valid_i,
  input  req_bundle_t   req_bundle_i,
  output logic          req_done_o,
  output logic          mtx_req_o,
  input  logic          mtx_gnt_i,
  output logic          scrmbl_valid_o,
  output scrmbl_cmd_e   scrmbl_cmd_o,
  output digest_sel_e   scrmbl_sel_o,
  input  logic          scrmbl_ready_i,
  input  logic          scrmbl_rvalid_i,
  output logic          edn_req_o,
  input  logic          edn_ack_i,
  output logic [1:0]    blk_idx_o,
  output logic          use_entropy_o,
  output logic          key_wr_o,
  output logic          key_half_o,
  output logic          nonce_wr_o,
  output logic [1:0]    nonce_idx_o,
  output logic          seed_valid_wr_o,
  output logic          fsm_err_o
);

  // Last EDN word of the 128 bit entropy block
  localparam logic [1:0] ingest_last = 2'(`KDI_KEY_W / `KDI_EDN_W - 1);

  typedef enum logic [3:0] {
    st_reset, st_idle, st_clear, st_load, st_fetch_entropy, st_entropy_digest,
    st_finalize, st_wait, st_fetch_nonce, st_finish, st_error
  } state_e;

  state_e     state_d, state_q;
  logic [1:0] blk_cnt_d, blk_cnt_q;
  logic [1:0] ent_cnt_d, ent_cnt_q;
  logic       edn_req_d, edn_req_q;
  logic       cmd_st;
  logic       xfer;
  logic       edn_word;
  logic [1:0] word_last;

  ////////////////////
  // Datapath handshake
  ////////////////////

  // States that issue a command
  assign cmd_st = state_q inside {st_clear, st_load, st_entropy_digest, st_finalize};
  // Nothing leaves without the mutex
  assign scrmbl_valid_o = cmd_st && mtx_gnt_i;
  assign xfer           = scrmbl_valid_o && scrmbl_ready_i;
  // Mutex held from clear through the last digest result
  assign mtx_req_o      = cmd_st || (state_q inside {st_fetch_entropy, st_wait});
  assign scrmbl_sel_o   = req_bundle_i.digest_sel;

  assign use_entropy_o = (state_q == st_entropy_digest);
  assign blk_idx_o     = blk_cnt_q;
  assign key_half_o    = blk_cnt_q[1];
  assign nonce_idx_o   = ent_cnt_q;
  assign edn_req_o     = edn_req_q;

  // Only acks to an open request count
  assign edn_word  = edn_req_q && edn_ack_i;
  assign word_last = (state_q == st_fetch_nonce) ? req_bundle_i.nonce_last : ingest_last;

  ////////////////////
  // Next state
  ////////////////////

  always_comb begin : p_fsm
    state_d         = state_q;
    blk_cnt_d       = blk_cnt_q;
    ent_cnt_d       = ent_cnt_q;
    // Open request drops on its ack, also from the error state
    edn_req_d       = edn_req_q && !edn_ack_i;
    scrmbl_cmd_o    = digest_load;
    key_wr_o        = 1'b0;
    nonce_wr_o      = 1'b0;
    seed_valid_wr_o = 1'b0;
    req_done_o      = 1'b0;
    fsm_err_o       = 1'b0;

    case (state_q)
      // Wait for the enable pulse
      st_reset: begin
        if (kdi_en_i) begin
          state_d = st_idle;
        end
      end
      st_idle: begin
        if (req_valid_i) begin
          blk_cnt_d = 2'd0;
          ent_cnt_d = 2'd0;
          state_d   = st_clear;
        end
      end
      // Reset digest state to the IV
      st_clear: begin
        scrmbl_cmd_o = digest_init;
        if (xfer) begin
          state_d = st_load;
        end
      end
      // Even block loads, odd block runs
      st_load: begin
        scrmbl_cmd_o = blk_cnt_q[0] ? digest_run : digest_load;
        if (xfer) begin
          if (!blk_cnt_q[0]) begin
            blk_cnt_d = blk_cnt_q + 2'd1;
          end else if (req_bundle_i.ingest_entropy) begin
            state_d = st_fetch_entropy;
          end else begin
            state_d = st_finalize;
          end
        end
      end
      // Both EDN phases share the word loop
      st_fetch_entropy, st_fetch_nonce: begin
        edn_req_d = 1'b1;
        if (edn_word) begin
          nonce_wr_o = 1'b1;
          if (ent_cnt_q == word_last) begin
            edn_req_d = 1'b0;
            ent_cnt_d = 2'd0;
            state_d   = (state_q == st_fetch_nonce) ? st_finish : st_entropy_digest;
          end else begin
            ent_cnt_d = ent_cnt_q + 2'd1;
          end
        end
      end
      // Two entropy blocks from the nonce registers
      st_entropy_digest: begin
        scrmbl_cmd_o = ent_cnt_q[0] ? digest_run : digest_load;
        if (xfer) begin
          if (ent_cnt_q[0]) begin
            ent_cnt_d = 2'd0;
            state_d   = st_finalize;
          end else begin
            ent_cnt_d = ent_cnt_q + 2'd1;
          end
        end
      end
      st_finalize: begin
        scrmbl_cmd_o = digest_finalize;
        if (xfer) begin
          state_d = st_wait;
        end
      end
      // Result is one key half
      st_wait: begin
        if (scrmbl_rvalid_i) begin
          key_wr_o = 1'b1;
          if (!blk_cnt_q[1]) begin
            blk_cnt_d = blk_cnt_q + 2'd1;
            state_d   = st_clear;
          end else begin
            blk_cnt_d       = 2'd0;
            seed_valid_wr_o = 1'b1;
            state_d         = st_fetch_nonce;
          end
        end
      end
      st_finish: begin
        req_done_o = 1'b1;
        state_d    = st_idle;
      end
      // Terminal
      st_error: begin
        fsm_err_o = 1'b1;
      end
      default: begin
        state_d   = st_error;
        fsm_err_o = 1'b1;
      end
    endcase

    // Escalation wins over everything
    if (escalate_i) begin
      state_d   = st_error;
      fsm_err_o = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      state_q   <= st_reset;
      blk_cnt_q <= 2'd0;
      ent_cnt_q <= 2'd0;
      edn_req_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      blk_cnt_q <= blk_cnt_d;
      ent_cnt_q <= ent_cnt_d;
      edn_req_q <= edn_req_d;
    end
  end

endmodule

/* source/kdi_defs.svh */
// Key derivation widths and counts

`ifndef KDI_DEFS_SVH
`define KDI_DEFS_SVH

////////////////////
// Datapath widths
////////////////////

// One digest block, as seen by the scrambling datapath
`define KDI_BLOCK_W 64

// Derived key, two digest blocks
`define KDI_KEY_W 128

////////////////////
// Seed widths
////////////////////

// Flash seeds fill all four digest blocks
`define KDI_FLASH_SEED_W 256

// SRAM seed covers two blocks and is used twice
`define KDI_SRAM_SEED_W 128

////////////////////
// Entropy and clients
////////////////////

// One EDN word per ack
`define KDI_EDN_W 32

// Nonce register depth in EDN words
`define KDI_NONCE_WORDS 4

// Flash data, flash address, SRAM
`define KDI_NUM_REQ 3

`endif

/* source/kdi_key_store.sv */
// Key and nonce result registers

`timescale 1ns/1ps
`include "kdi_defs.svh"

module kdi_key_store
  import kdi_req_pkg::*;
(
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  req_bundle_t                               req_bundle_i,
  input  logic [1:0]                                blk_idx_i,
  input  logic                                      use_entropy_i,
  input  logic                                      key_wr_i,
  input  logic                                      key_half_i,
  input  logic [`KDI_BLOCK_W-1:0]                   scrmbl_rdata_i,
  input  logic                                      nonce_wr_i,
  input  logic [1:0]                                nonce_idx_i,
  input  logic [`KDI_EDN_W-1:0]                     edn_data_i,
  input  logic                                      seed_valid_wr_i,
  output logic [`KDI_BLOCK_W-1:0]                   scrmbl_data_o,
  output logic [`KDI_KEY_W-1:0]                     key_o,
  output logic [`KDI_NONCE_WORDS*`KDI_EDN_W-1:0]    nonce_o,
  output logic                                      seed_valid_o
);

  logic [1:0][`KDI_BLOCK_W-1:0]                 key_q;
  logic [`KDI_NONCE_WORDS-1:0][`KDI_EDN_W-1:0]  nonce_q;
  logic                                         seed_valid_q;
  // Nonce words viewed as two digest blocks
  logic [1:0][`KDI_BLOCK_W-1:0]                 ent_blk;

  ////////////////////
  // Output registers
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_store
    if (!rst_ni) begin
      key_q        <= '0;
      nonce_q      <= '0;
      seed_valid_q <= 1'b0;
    end else begin
      // Digest result lands in the current half
      if (key_wr_i) begin
        key_q[key_half_i] <= scrmbl_rdata_i;
      end
      // Ingest entropy and nonce share these words
      if (nonce_wr_i) begin
        nonce_q[nonce_idx_i] <= edn_data_i;
      end
      if (seed_valid_wr_i) begin
        seed_valid_q <= req_bundle_i.seed_valid;
      end
    end
  end

  ////////////////////
  // Datapath data
  ////////////////////

  assign ent_blk = nonce_q;

  // Entropy block follows the entropy counter, seed is zero when invalid
  assign scrmbl_data_o = use_entropy_i           ? ent_blk[nonce_idx_i[0]] :
                         req_bundle_i.seed_valid ? req_bundle_i.seed[blk_idx_i] : '0;

  assign key_o        = key_q;
  assign nonce_o      = nonce_q;
  assign seed_valid_o = seed_valid_q;

endmodule

/* source/kdi_req_decode.sv */
// Key request arbiter and decoder

`timescale 1ns/1ps
`include "kdi_defs.svh"

module kdi_req_decode
  import kdi_scrmbl_pkg::*;
  import kdi_req_pkg::*;
(
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  key_req_t [`KDI_NUM_REQ-1:0]       key_req_i,
  input  logic                              seed_valid_i,
  input  logic [`KDI_FLASH_SEED_W-1:0]      flash_data_seed_i,
  input  logic [`KDI_FLASH_SEED_W-1:0]      flash_addr_seed_i,
  input  logic [`KDI_SRAM_SEED_W-1:0]       sram_seed_i,
  input  logic                              req_done_i,
  output logic [`KDI_NUM_REQ-1:0]           ack_o,
  output logic                              req_valid_o,
  output req_bundle_t                       req_bundle_o
);

  ////////////////////
  // Client bundles
  ////////////////////

  req_bundle_t bundles [`KDI_NUM_REQ];

  // Flash data key, full nonce
  assign bundles[0] = '{ingest_entropy: 1'b0, digest_sel: flash_data_sel,
                        nonce_last: 2'(`KDI_NONCE_WORDS - 1),
                        seed_valid: seed_valid_i, seed: flash_data_seed_i};
  // Flash address key, one nonce word
  assign bundles[1] = '{ingest_entropy: 1'b0, digest_sel: flash_addr_sel,
                        nonce_last: 2'd0,
                        seed_valid: seed_valid_i, seed: flash_addr_seed_i};
  // SRAM key mixes in entropy, seed fills both halves
  assign bundles[2] = '{ingest_entropy: 1'b1, digest_sel: sram_data_sel,
                        nonce_last: 2'(`KDI_NONCE_WORDS - 1),
                        seed_valid: seed_valid_i, seed: {sram_seed_i, sram_seed_i}};

  ////////////////////
  // Round robin
  ////////////////////

  logic       busy_q;
  logic [1:0] gnt_idx_q;
  logic [1:0] ptr_q;
  logic [1:0] pick_idx;
  logic       pick_found;

  // Search from the priority pointer, first requester wins
  always_comb begin : p_pick
    int unsigned idx;
    pick_found = 1'b0;
    pick_idx   = 2'd0;
    for (int unsigned i = 0; i < `KDI_NUM_REQ; i++) begin
      idx = (ptr_q + i) % `KDI_NUM_REQ;
      if (!pick_found && key_req_i[idx].req) begin
        pick_found = 1'b1;
        pick_idx   = 2'(idx);
      end
    end
  end

  // Grant locks until the FSM signals completion
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_arb
    if (!rst_ni) begin
      busy_q    <= 1'b0;
      gnt_idx_q <= 2'd0;
      ptr_q     <= 2'd0;
    end else if (busy_q) begin
      if (req_done_i) begin
        busy_q <= 1'b0;
        // Client after the served one gets top priority
        ptr_q  <= (gnt_idx_q == 2'(`KDI_NUM_REQ - 1)) ? 2'd0 : gnt_idx_q + 2'd1;
      end
    end else if (pick_found) begin
      busy_q    <= 1'b1;
      gnt_idx_q <= pick_idx;
    end
  end

  // Ack goes out in the FSM finish cycle
  always_comb begin : p_ack
    for (int unsigned k = 0; k < `KDI_NUM_REQ; k++) begin
      ack_o[k] = busy_q && req_done_i && (gnt_idx_q == 2'(k));
    end
  end

  assign req_valid_o  = busy_q;
  assign req_bundle_o = bundles[gnt_idx_q];

endmodule

/* source/kdi_req_pkg.sv */
// Key request and response types

`include "kdi_defs.svh"

package kdi_req_pkg;

  import kdi_scrmbl_pkg::*;

  ////////////////////
  // Client interface
  ////////////////////

  // Held high until the matching ack
  typedef struct packed {
    logic req;
  } key_req_t;

  // Key, nonce and seed status are valid in the ack cycle and hold afterwards
  typedef struct packed {
    logic                                      ack;
    logic [`KDI_KEY_W-1:0]                     key;
    logic [`KDI_NONCE_WORDS*`KDI_EDN_W-1:0]    nonce;
    logic                                      seed_valid;
  } key_rsp_t;

  ////////////////////
  // Decoded request
  ////////////////////

  // Per-client configuration for the control FSM
  typedef struct packed {
    // Feed 128 bits of entropy after each seed pair
    logic                             ingest_entropy;
    // Digest IV select
    digest_sel_e                      digest_sel;
    // Index of the final nonce word
    logic [1:0]                       nonce_last;
    // Seed blocks are forced to zero when low
    logic                             seed_valid;
    // Four seed blocks, two per key half
    logic [3:0][`KDI_BLOCK_W-1:0]     seed;
  } req_bundle_t;

endpackage

/* source/kdi_scrmbl_pkg.sv */
// Scrambling datapath command types

`include "kdi_defs.svh"

package kdi_scrmbl_pkg;

  ////////////////////
  // Commands
  ////////////////////

  // Digest commands understood by the external datapath
  typedef enum logic [1:0] {
    digest_init     = 2'd0,
    digest_load     = 2'd1,
    digest_run      = 2'd2,
    digest_finalize = 2'd3
  } scrmbl_cmd_e;

  // Netlist constant index, picks the digest IV
  typedef enum logic [1:0] {
    flash_data_sel = 2'd0,
    flash_addr_sel = 2'd1,
    sram_data_sel  = 2'd2
  } digest_sel_e;

  ////////////////////
  // Request bundle
  ////////////////////

  // One datapath transfer, taken when valid and ready meet
  typedef struct packed {
    logic                     valid;
    scrmbl_cmd_e              cmd;
    digest_sel_e              sel;
    logic [`KDI_BLOCK_W-1:0]  data;
  } scrmbl_req_t;

endpackage

/* source/kdi_top.sv */
// Key derivation unit top level

`timescale 1ns/1ps
`include "kdi_defs.svh"

module kdi_top
  import kdi_scrmbl_pkg::*;
  import kdi_req_pkg::*;
(
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           kdi_en_i,
  input  logic                           escalate_i,
  input  logic                           seed_valid_i,
  input  logic [`KDI_FLASH_SEED_W-1:0]   flash_data_seed_i,
  input  logic [`KDI_FLASH_SEED_W-1:0]   flash_addr_seed_i,
  input  logic [`KDI_SRAM_SEED_W-1:0]    sram_seed_i,
  input  key_req_t [`KDI_NUM_REQ-1:0]    key_req_i,
  output key_rsp_t [`KDI_NUM_REQ-1:0]    key_rsp_o,
  output logic                           mtx_req_o,
  input  logic                           mtx_gnt_i,
  output scrmbl_req_t                    scrmbl_o,
  input  logic                           scrmbl_ready_i,
  input  logic                           scrmbl_rvalid_i,
  input  logic [`KDI_BLOCK_W-1:0]        scrmbl_rdata_i,
  output logic                           edn_req_o,
  input  logic                           edn_ack_i,
  input  logic [`KDI_EDN_W-1:0]          edn_data_i,
  output logic                           fsm_err_o
);

  logic [`KDI_NUM_REQ-1:0]                  ack;
  logic                                     req_valid;
  logic                                     req_done;
  req_bundle_t                              req_bundle;
  logic                                     scrmbl_valid;
  scrmbl_cmd_e                              scrmbl_cmd;
  digest_sel_e                              scrmbl_sel;
  logic [`KDI_BLOCK_W-1:0]                  scrmbl_data;
  logic [1:0]                               blk_idx;
  logic                                     use_entropy;
  logic                                     key_wr;
  logic                                     key_half;
  logic                                     nonce_wr;
  logic [1:0]                               nonce_idx;
  logic                                     seed_valid_wr;
  logic [`KDI_KEY_W-1:0]                    key;
  logic [`KDI_NONCE_WORDS*`KDI_EDN_W-1:0]   nonce;
  logic                                     seed_valid;

  ////////////////////
  // Decode
  ////////////////////

  kdi_req_decode u_decode (
    .clk_i,
    .rst_ni,
    .key_req_i,
    .seed_valid_i,
    .flash_data_seed_i,
    .flash_addr_seed_i,
    .sram_seed_i,
    .req_done_i   (req_done),
    .ack_o        (ack),
    .req_valid_o  (req_valid),
    .req_bundle_o (req_bundle)
  );

  ////////////////////
  // Control
  ////////////////////

  kdi_ctrl_fsm u_ctrl (
    .clk_i,
    .rst_ni,
    .kdi_en_i,
    .escalate_i,
    .req_valid_i     (req_valid),
    .req_bundle_i    (req_bundle),
    .req_done_o      (req_done),
    .mtx_req_o,
    .mtx_gnt_i,
    .scrmbl_valid_o  (scrmbl_valid),
    .scrmbl_cmd_o    (scrmbl_cmd),
    .scrmbl_sel_o    (scrmbl_sel),
    .scrmbl_ready_i,
    .scrmbl_rvalid_i,
    .edn_req_o,
    .edn_ack_i,
    .blk_idx_o       (blk_idx),
    .use_entropy_o   (use_entropy),
    .key_wr_o        (key_wr),
    .key_half_o      (key_half),
    .nonce_wr_o      (nonce_wr),
    .nonce_idx_o     (nonce_idx),
    .seed_valid_wr_o (seed_valid_wr),
    .fsm_err_o
  );

  ////////////////////
  // Result
  ////////////////////

  kdi_key_store u_store (
    .clk_i,
    .rst_ni,
    .req_bundle_i    (req_bundle),
    .blk_idx_i       (blk_idx),
    .use_entropy_i   (use_entropy),
    .key_wr_i        (key_wr),
    .key_half_i      (key_half),
    .scrmbl_rdata_i,
    .nonce_wr_i      (nonce_wr),
    .nonce_idx_i     (nonce_idx),
    .edn_data_i,
    .seed_valid_wr_i (seed_valid_wr),
    .scrmbl_data_o   (scrmbl_data),
    .key_o           (key),
    .nonce_o         (nonce),
    .seed_valid_o    (seed_valid)
  );

  // Datapath command, data comes from the store
  assign scrmbl_o = '{valid: scrmbl_valid, cmd: scrmbl_cmd, sel: scrmbl_sel,
                      data: scrmbl_data};

  // All clients see the shared key and nonce, only the ack differs
  for (genvar k = 0; k < `KDI_NUM_REQ; k++) begin : gen_rsp
    assign key_rsp_o[k] = '{ack: ack[k], key: key, nonce: nonce, seed_valid: seed_valid};
  end

endmodule

/* verification/kdi_assertions.sv */
// Key derivation protocol checks

`timescale 1ns/1ps

module kdi_assertions
  import kdi_scrmbl_pkg::*;
(
  input logic        clk_i,
  input logic        rst_ni,
  input logic        edn_req_i,
  input logic        edn_ack_i,
  input scrmbl_req_t scrmbl_i,
  input logic        scrmbl_ready_i,
  input logic        scrmbl_rvalid_i,
  input logic        mtx_req_i,
  input logic        fsm_err_i
);

  ////////////////////
  // Handshakes
  ////////////////////

  // EDN request stays up until its ack
  a_edn_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    edn_req_i && !edn_ack_i |=> edn_req_i)
    else $error("edn_req_o dropped before edn_ack_i");

  // Datapath command waits for ready unless the error state aborts it
  a_scrmbl_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    scrmbl_i.valid && !scrmbl_ready_i |=> scrmbl_i.valid || fsm_err_i)
    else $error("scrmbl_o.valid dropped before scrmbl_ready_i");

  // Mutex drops only after a digest result or in the error state
  a_mtx_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(mtx_req_i) |-> $past(scrmbl_rvalid_i) || fsm_err_i)
    else $error("mtx_req_o fell before the digest result");

  ////////////////////
  // Error state
  ////////////////////

  // Error state never clears
  a_err_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fsm_err_i |=> fsm_err_i)
    else $error("fsm_err_o fell after rising");

endmodule

bind kdi_top kdi_assertions u_assertions (
  .clk_i           (clk_i),
  .rst_ni          (rst_ni),
  .edn_req_i       (edn_req_o),
  .edn_ack_i       (edn_ack_i),
  .scrmbl_i        (scrmbl_o),
  .scrmbl_ready_i  (scrmbl_ready_i),
  .scrmbl_rvalid_i (scrmbl_rvalid_i),
  .mtx_req_i       (mtx_req_o),
  .fsm_err_i       (fsm_err_o)
);

/* verification/kdi_tb.sv */
// Key derivation unit testbench

`timescale 1ns/1ps
`include "kdi_defs.svh"

module kdi_tb
  import kdi_scrmbl_pkg::*;
  import kdi_req_pkg::*;
();

  localparam int num_tests       = 7;
  localparam int cycles_per_test = 400;
  localparam int reset_cycles    = 8;
  localparam int watch_cycles    = 200;

  // One table row of stimulus and the expected ack
  typedef struct packed {
    logic [2:0]  clients;
    logic        seed_valid;
    logic [31:0] seed_tag;
    logic        escalate;
    logic        exp_ack;
  } test_row_t;

  localparam test_row_t test_table [num_tests] = '{
    // clients, seed_valid, seed tag, escalate, ack expected
    '{3'b001, 1'b1, 32'h1c0ffee1, 1'b0, 1'b1},
    '{3'b010, 1'b1, 32'h2badf00d, 1'b0, 1'b1},
    '{3'b100, 1'b1, 32'h37e11a55, 1'b0, 1'b1},
    '{3'b100, 1'b0, 32'h4d15ea5e, 1'b0, 1'b1},
    '{3'b001, 1'b0, 32'h5eed0001, 1'b0, 1'b1},
    '{3'b111, 1'b1, 32'h6a11c0de, 1'b0, 1'b1},
    // Escalation stays last since the error state is terminal
    '{3'b001, 1'b1, 32'h7e5ca1a7, 1'b1, 1'b0}
  };

  logic                               clk_i;
  logic                               rst_ni;
  logic                               kdi_en_i;
  logic                               escalate_i;
  logic                               seed_valid_i;
  logic [`KDI_FLASH_SEED_W-1:0]       flash_data_seed_i;
  logic [`KDI_FLASH_SEED_W-1:0]       flash_addr_seed_i;
  logic [`KDI_SRAM_SEED_W-1:0]        sram_seed_i;
  key_req_t [`KDI_NUM_REQ-1:0]        key_req_i;
  key_rsp_t [`KDI_NUM_REQ-1:0]        key_rsp_o;
  logic                               mtx_req_o;
  logic                               mtx_gnt_i = 1'b0;
  scrmbl_req_t                        scrmbl_o;
  logic                               scrmbl_ready_i = 1'b0;
  logic                               scrmbl_rvalid_i = 1'b0;
  logic [`KDI_BLOCK_W-1:0]            scrmbl_rdata_i = '0;
  logic                               edn_req_o;
  logic                               edn_ack_i = 1'b0;
  logic [`KDI_EDN_W-1:0]              edn_data_i = '0;
  logic                               fsm_err_o;

  // Model state
  logic [31:0]                        rng_q;
  logic [`KDI_BLOCK_W-1:0]            dp_state_q;
  logic [1:0]                         fin_cnt_q;
  logic [2:0]                         edn_wait_q;
  logic [`KDI_EDN_W-1:0]              ent_log [$];
  logic [`KDI_EDN_W-1:0]              exp_nonce [`KDI_NONCE_WORDS];
  int                                 errors = 0;
  int                                 tests_failed = 0;
  int                                 rr_ptr = 0;
  int unsigned                        cycles = 0;

  kdi_top DUT (.*);

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Digest start value per netlist constant
  function automatic logic [63:0] digest_iv(input digest_sel_e sel);
    case (sel)
      flash_data_sel: return 64'hb6a4_1c37_0e95_d2f8;
      flash_addr_sel: return 64'h49e1_73ac_5d20_8b16;
      sram_data_sel:  return 64'hd03f_6e52_a7c8_1947;
      default:        return '0;
    endcase
  endfunction

  function automatic digest_sel_e client_sel(input int k);
    case (k)
      0:       return flash_data_sel;
      1:       return flash_addr_sel;
      default: return sram_data_sel;
    endcase
  endfunction

  // Every word of the seed depends on its position
  function automatic logic [255:0] spread_seed(input logic [31:0] tag);
    logic [255:0] s;
    for (int i = 0; i < 8; i++) begin
      s[32*i +: 32] = tag ^ 32'(32'h9e3779b9 * 32'(i + 1));
    end
    return s;
  endfunction

  // Round robin from the modelled pointer
  function automatic int next_in_order(input logic [2:0] pending);
    int idx;
    for (int i = 0; i < `KDI_NUM_REQ; i++) begin
      idx = (rr_ptr + i) % `KDI_NUM_REQ;
      if (pending[idx]) begin
        return idx;
      end
    end
    return -1;
  endfunction

  task automatic pop_word(input int k, output logic [31:0] w);
    if (ent_log.size() == 0) begin
      $display("Entropy log ran out of words while serving client %0d", k);
      errors++;
      w = '0;
    end else begin
      w = ent_log.pop_front();
    end
  endtask

  // Key per half is the IV with seed and entropy blocks folded in
  task automatic expect_rsp(input int k, input logic sv, output key_rsp_t exp);
    logic [255:0] seed;
    logic [63:0]  half;
    logic [31:0]  w [4];
    int           n;
    exp = '0;
    exp.ack = 1'b1;
    exp.seed_valid = sv;
    seed = (k == 0) ? flash_data_seed_i :
           (k == 1) ? flash_addr_seed_i : {sram_seed_i, sram_seed_i};
    for (int h = 0; h < 2; h++) begin
      half = digest_iv(client_sel(k));
      if (sv) begin
        half = half ^ seed[128*h +: 64] ^ seed[128*h+64 +: 64];
      end
      // SRAM half mixes in four fresh entropy words
      if (k == 2) begin
        for (int i = 0; i < 4; i++) begin
          pop_word(k, w[i]);
        end
        half = half ^ {w[1], w[0]} ^ {w[3], w[2]};
      end
      exp.key[64*h +: 64] = half;
    end
    // Flash address fetches one nonce word and the rest hold
    n = (k == 1) ? 1 : `KDI_NONCE_WORDS;
    for (int i = 0; i < n; i++) begin
      pop_word(k, exp_nonce[i]);
    end
    for (int i = 0; i < `KDI_NONCE_WORDS; i++) begin
      exp.nonce[32*i +: 32] = exp_nonce[i];
    end
  endtask

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_rsp(input key_rsp_t got, input key_rsp_t exp, input string name);
    if (got.ack !== exp.ack) begin
      $display("Error %0t: %s.ack = %b, expected %b", $time, name, got.ack, exp.ack);
      errors++;
    end
    if (got.key !== exp.key) begin
      $display("Error %0t: %s.key = %h, expected %h", $time, name, got.key, exp.key);
      errors++;
    end
    if (got.nonce !== exp.nonce) begin
      $display("Error %0t: %s.nonce = %h, expected %h", $time, name, got.nonce, exp.nonce);
      errors++;
    end
    if (got.seed_valid !== exp.seed_valid) begin
      $display("Error %0t: %s.seed_valid = %b, expected %b", $time, name,
               got.seed_valid, exp.seed_valid);
      errors++;
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      $display("Error %0t: %s = %b, expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  ////////////////////
  // Clock and models
  ////////////////////

  initial begin : p_clk
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin : p_watchdog
    cycles <= cycles + 1;
    if (cycles >= num_tests * cycles_per_test) begin
      $display("Timeout: the tests did not finish within %0d cycles", cycles);
      $display("Done: errors found");
      $finish;
    end
  end

  // Mutex, datapath and EDN share one generator stream
  always @(posedge clk_i or negedge rst_ni) begin : p_models
    logic [31:0] rnd;
    logic [31:0] word;
    if (!rst_ni) begin
      rng_q           <= 32'h893d7eba;
      mtx_gnt_i       <= 1'b0;
      scrmbl_ready_i  <= 1'b0;
      scrmbl_rvalid_i <= 1'b0;
      scrmbl_rdata_i  <= '0;
      dp_state_q      <= '0;
      fin_cnt_q       <= 2'd0;
      edn_ack_i       <= 1'b0;
      edn_data_i      <= '0;
      edn_wait_q      <= 3'd0;
    end else begin
      rnd = lcg_next(rng_q);
      rng_q <= rnd;
      // Grant trails the request by one cycle
      mtx_gnt_i      <= mtx_req_o;
      scrmbl_ready_i <= (rnd[17:16] != 2'b00);
      // Result two cycles after finalize
      scrmbl_rvalid_i <= 1'b0;
      if (fin_cnt_q != 2'd0) begin
        fin_cnt_q <= fin_cnt_q - 2'd1;
        if (fin_cnt_q == 2'd1) begin
          scrmbl_rvalid_i <= 1'b1;
          scrmbl_rdata_i  <= dp_state_q;
        end
      end
      if (scrmbl_o.valid && scrmbl_ready_i) begin
        case (scrmbl_o.cmd)
          digest_init:     dp_state_q <= digest_iv(scrmbl_o.sel);
          digest_finalize: fin_cnt_q  <= 2'd2;
          default:         dp_state_q <= dp_state_q ^ scrmbl_o.data;
        endcase
      end
      // EDN acks after a random wait and logs every word
      if (edn_ack_i) begin
        edn_ack_i <= 1'b0;
      end else if (edn_req_o) begin
        if (edn_wait_q == 3'd0) begin
          word = lcg_next(rnd);
          rng_q      <= word;
          edn_ack_i  <= 1'b1;
          edn_data_i <= word;
          edn_wait_q <= word[30:28];
          ent_log.push_back(word);
        end else begin
          edn_wait_q <= edn_wait_q - 3'd1;
        end
      end
    end
  end

  ////////////////////
  // Test sequences
  ////////////////////

  task automatic escalate_mid_request(input logic exp_ack);
    // Let the digest sequence get going first
    while (!mtx_req_o) begin
      @(posedge clk_i);
    end
    repeat (3) @(posedge clk_i);
    escalate_i <= 1'b1;
    @(posedge clk_i);
    escalate_i <= 1'b0;
    check_bit(fsm_err_o, 1'b1, "fsm_err_o");
    repeat (watch_cycles) begin
      @(posedge clk_i);
      for (int j = 0; j < `KDI_NUM_REQ; j++) begin
        if (key_rsp_o[j].ack) begin
          check_bit(key_rsp_o[j].ack, exp_ack, $sformatf("key_rsp_o[%0d].ack", j));
        end
      end
    end
    check_bit(fsm_err_o, 1'b1, "fsm_err_o");
  endtask

  task automatic run_test(input int t);
    test_row_t  row;
    logic [2:0] pending;
    key_rsp_t   exp;
    int         err_start;
    int         exp_k;
    int         got_k;
    row = test_table[t];
    err_start = errors;
    ent_log.delete();
    @(posedge clk_i);
    check_bit(fsm_err_o, 1'b0, "fsm_err_o");
    seed_valid_i      <= row.seed_valid;
    flash_data_seed_i <= spread_seed(row.seed_tag);
    flash_addr_seed_i <= spread_seed(~row.seed_tag);
    sram_seed_i       <= 128'(spread_seed(row.seed_tag ^ 32'h5a5a0f0f));
    for (int k = 0; k < `KDI_NUM_REQ; k++) begin
      key_req_i[k].req <= row.clients[k];
    end
    if (row.escalate) begin
      escalate_mid_request(row.exp_ack);
    end else begin
      pending = row.clients;
      while (pending != 3'b000) begin
        @(posedge clk_i);
        got_k = -1;
        for (int j = `KDI_NUM_REQ - 1; j >= 0; j--) begin
          if (key_rsp_o[j].ack) begin
            got_k = j;
          end
        end
        if (got_k >= 0) begin
          // Only the next client in round-robin order may see an ack
          exp_k = next_in_order(pending);
          for (int j = 0; j < `KDI_NUM_REQ; j++) begin
            check_bit(key_rsp_o[j].ack, (j == exp_k) && row.exp_ack,
                      $sformatf("key_rsp_o[%0d].ack", j));
          end
          expect_rsp(got_k, row.seed_valid, exp);
          check_rsp(key_rsp_o[got_k], exp, $sformatf("key_rsp_o[%0d]", got_k));
          pending[got_k] = 1'b0;
          key_req_i[got_k].req <= 1'b0;
          rr_ptr = (got_k + 1) % `KDI_NUM_REQ;
        end
      end
    end
    for (int k = 0; k < `KDI_NUM_REQ; k++) begin
      key_req_i[k].req <= 1'b0;
    end
    if (errors != err_start) begin
      tests_failed++;
    end
    $display("Test %0d clients %b seed_valid %b escalate %b: %s", t, row.clients,
             row.seed_valid, row.escalate, (errors == err_start) ? "ok" : "FAILED");
  endtask

  initial begin : p_main
    rst_ni            = 1'b0;
    kdi_en_i          = 1'b0;
    escalate_i        = 1'b0;
    seed_valid_i      = 1'b0;
    flash_data_seed_i = '0;
    flash_addr_seed_i = '0;
    sram_seed_i       = '0;
    key_req_i         = '0;
    for (int i = 0; i < `KDI_NONCE_WORDS; i++) begin
      exp_nonce[i] = '0;
    end
    repeat (reset_cycles) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    // Outputs idle and responses cleared after reset
    check_bit(edn_req_o, 1'b0, "edn_req_o");
    check_bit(mtx_req_o, 1'b0, "mtx_req_o");
    check_bit(scrmbl_o.valid, 1'b0, "scrmbl_o.valid");
    for (int k = 0; k < `KDI_NUM_REQ; k++) begin
      check_rsp(key_rsp_o[k], '0, $sformatf("key_rsp_o[%0d]", k));
    end
    kdi_en_i <= 1'b1;
    @(posedge clk_i);
    kdi_en_i <= 1'b0;
    for (int t = 0; t < num_tests; t++) begin
      run_test(t);
    end
    $display("Tests run: %0d, failed: %0d, errors: %0d", num_tests, tests_failed, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
